// File: rtl/branchResolver.sv
`timescale 1ns/1ns
`default_nettype none

module branchResolver
(
    input  controlPkg::branchRequest_t       branchRequest,
    input  isaPkg::psr_t                     Psr,
    output logic [isaPkg::PcOffsetWidth-1:0] pcOffset
);

    import isaPkg::*;
    import controlPkg::*;

    // Plain sequential step
    localparam logic [PcOffsetWidth-1:0] StepNext = 8'd1;
    // Step over the following word
    localparam logic [PcOffsetWidth-1:0] StepSkip = 8'd2;

    logic condHolds;

    //////////////////////////////////////////////////////////////////////
    // Condition test
    //////////////////////////////////////////////////////////////////////

    // Flag sense follows the ALU compare convention
    always_comb
    begin
        case (branchRequest.cond)
            GreaterEqual:
                condHolds = !Psr.zero && !Psr.low;
            Higher:
                condHolds = !Psr.zero && !Psr.greater;
            Equal:
                condHolds = !Psr.zero;
            LessThan:
                condHolds = Psr.zero || Psr.low;
            LowerSame:
                condHolds = Psr.greater;
            default:
                condHolds = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Step choice
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (branchRequest.kind)
            Skip:
                pcOffset = condHolds ? StepSkip : StepNext;
            Jump:
                pcOffset = condHolds ? branchRequest.jumpOffset : StepNext;
            // Also covers the register jump, zeroed downstream
            default:
                pcOffset = StepNext;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/controlPkg.sv
`default_nettype none

package controlPkg;

    import isaPkg::*;

    //////////////////////////////////////////////////////////////////////
    // Datapath selections
    //////////////////////////////////////////////////////////////////////

    // Second ALU operand source
    typedef enum logic [1:0] {
        SrcImmediate      = 2'd0,
        SrcRegister       = 2'd1,
        SrcMemory         = 2'd2,
        SrcProgramCounter = 2'd3
    } aluSrc_t;

    //////////////////////////////////////////////////////////////////////
    // Branch request from decoder to resolver
    //////////////////////////////////////////////////////////////////////

    // Skip steps over one word, Jump adds the instruction offset
    typedef enum logic [1:0] {
        NoBranch = 2'd0,
        Skip     = 2'd1,
        Jump     = 2'd2
    } branchKind_t;

    typedef struct packed {
        branchKind_t              kind;
        condition_t               cond;
        logic [PcOffsetWidth-1:0] jumpOffset;
    } branchRequest_t;

    //////////////////////////////////////////////////////////////////////
    // Control word to the datapath
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        // ALU operation
        logic [3:0]               opCode;
        logic [3:0]               opExt;
        // Register file ports
        logic                     regWrite;
        logic [RegIndexWidth-1:0] regIn;
        logic [RegIndexWidth-1:0] regA;
        logic [RegIndexWidth-1:0] regB;
        // Extended immediate and program-counter step
        logic [DataWidth-1:0]     immediate;
        logic [PcOffsetWidth-1:0] pcOffset;
        // Source and write enables
        aluSrc_t                  aluSrc;
        logic                     memAddrFromPc;
        logic                     memWrite;
        logic                     irWrite;
        logic                     pcWrite;
        logic                     pcIncrement;
    } controlWord_t;

endpackage

`default_nettype wire

// File: rtl/controlSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module controlSequencer
(
    input  logic                             Clock,
    input  logic                             Reset,
    input  controlPkg::controlWord_t         decodedWord,
    input  logic [isaPkg::PcOffsetWidth-1:0] pcOffset,
    output controlPkg::controlWord_t         Control
);

    import controlPkg::*;

    // Low in fetch, high in execute
    logic         executePhase;
    // Fixed word for the fetch phase
    controlWord_t fetchWord;
    // Decoded word with the resolved step
    controlWord_t executeWord;

    //////////////////////////////////////////////////////////////////////
    // Phase register
    //////////////////////////////////////////////////////////////////////

    // Reset leaves the phase at fetch, then it flips every clock
    always_ff @(posedge Clock or negedge Reset)
    begin
        if (!Reset)
            executePhase <= 1'b0;
        else
            executePhase <= ~executePhase;
    end

    //////////////////////////////////////////////////////////////////////
    // Phase words
    //////////////////////////////////////////////////////////////////////

    // Fetch reads memory at the PC into the instruction register
    always_comb
    begin
        fetchWord = '0;
        fetchWord.memAddrFromPc = 1'b1;
        fetchWord.irWrite = 1'b1;
    end

    // A register jump loads the PC outright, so its step stays zero
    always_comb
    begin
        executeWord = decodedWord;
        if (decodedWord.pcWrite)
            executeWord.pcOffset = '0;
        else
            executeWord.pcOffset = pcOffset;
    end

    //////////////////////////////////////////////////////////////////////
    // Output select
    //////////////////////////////////////////////////////////////////////

    // All controls held inactive while in reset
    always_comb
    begin
        if (!Reset)
            Control = '0;
        else if (executePhase)
            Control = executeWord;
        else
            Control = fetchWord;
    end

endmodule

`default_nettype wire

// File: rtl/cpuController.sv
`timescale 1ns/1ns
`default_nettype none

module cpuController
(
    input  logic                     Clock,
    input  logic                     Reset,
    input  isaPkg::instrWord_t       Ins,
    input  isaPkg::psr_t             Psr,
    output controlPkg::controlWord_t Control
);

    import isaPkg::*;
    import controlPkg::*;

    // Execute-phase word before the step is inserted
    controlWord_t             decodedWord;
    // Condition and offset handed to the resolver
    branchRequest_t           branchRequest;
    // Resolved program-counter step
    logic [PcOffsetWidth-1:0] pcOffset;

    // Opcode classification and field routing
    instructionDecoder decoder0
    (
        .Ins           (Ins),
        .decodedWord   (decodedWord),
        .branchRequest (branchRequest)
    );

    // Flag test and step choice
    branchResolver resolver0
    (
        .branchRequest (branchRequest),
        .Psr           (Psr),
        .pcOffset      (pcOffset)
    );

    // Fetch/execute phase and output select
    controlSequencer sequencer0
    (
        .Clock       (Clock),
        .Reset       (Reset),
        .decodedWord (decodedWord),
        .pcOffset    (pcOffset),
        .Control     (Control)
    );

endmodule

`default_nettype wire

// File: rtl/instructionDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instructionDecoder
(
    input  isaPkg::instrWord_t         Ins,
    output controlPkg::controlWord_t   decodedWord,
    output controlPkg::branchRequest_t branchRequest
);

    import isaPkg::*;
    import controlPkg::*;

    // Immediate field is the middle byte
    localparam int ImmFieldWidth = DataWidth / 2;
    localparam int ImmPadWidth = DataWidth - ImmFieldWidth;

    // Memory sub-operations in opExt
    localparam logic [3:0] LoadExt = 4'd0;
    localparam logic [3:0] StoreExt = 4'd1;
    // Special jump sub-operations in opExt
    localparam logic [3:0] RegJumpExt = 4'd0;
    localparam logic [3:0] StorePcExt = 4'd1;

    logic [InstrWidth-1:0]    insBits;
    opCode_t                  opCode;
    condition_t               cond;
    logic                     condValid;
    logic [ImmFieldWidth-1:0] immByte;
    logic [DataWidth-1:0]     immSigned;
    logic [DataWidth-1:0]     immUnsigned;
    logic [DataWidth-1:0]     immUpper;
    logic [DataWidth-1:0]     immOnes;
    logic [DataWidth-1:0]     immValue;

    assign insBits = Ins;
    assign opCode = opCode_t'(Ins.opCode);
    assign cond = condition_t'(Ins.opExt);

    //////////////////////////////////////////////////////////////////////
    // Immediate extension
    //////////////////////////////////////////////////////////////////////

    assign immByte = {Ins.opExt, Ins.fieldHigh};

    // Four ways to widen the byte
    assign immSigned = {{ImmPadWidth{immByte[ImmFieldWidth-1]}}, immByte};
    assign immUnsigned = {{ImmPadWidth{1'b0}}, immByte};
    assign immUpper = {immByte, {ImmPadWidth{1'b0}}};
    assign immOnes = {{ImmPadWidth{1'b1}}, immByte};

    always_comb
    begin
        case (opCode)
            AddImm, SubImm:       immValue = immSigned;
            AddUnsImm, MoveImm:   immValue = immUnsigned;
            MoveUpperImm:         immValue = immUpper;
            CompareImm:           immValue = immOnes;
            default:              immValue = '0;
        endcase
    end

    // Only five condition codes are defined
    always_comb
    begin
        case (cond)
            GreaterEqual, Higher, Equal, LessThan, LowerSame:
                condValid = 1'b1;
            default:
                condValid = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Opcode classification
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // No-op unless an arm below claims the encoding
        decodedWord = '0;
        decodedWord.aluSrc = SrcImmediate;
        decodedWord.pcIncrement = 1'b1;
        branchRequest = '0;
        branchRequest.kind = NoBranch;

        case (opCode)
            // rA op rB into rB
            RegAlu:
            begin
                decodedWord.opCode = Ins.opCode;
                decodedWord.opExt = Ins.opExt;
                decodedWord.regWrite = 1'b1;
                decodedWord.regIn = Ins.fieldLow;
                decodedWord.regA = Ins.fieldHigh;
                decodedWord.regB = Ins.fieldLow;
                decodedWord.aluSrc = SrcRegister;
            end
            // Flags only, no write back
            Compare:
            begin
                decodedWord.opCode = Ins.opCode;
                decodedWord.opExt = Ins.opExt;
                decodedWord.regA = Ins.fieldHigh;
                decodedWord.regB = Ins.fieldLow;
                decodedWord.aluSrc = SrcRegister;
            end
            // Immediate into fieldLow
            AddImm, AddUnsImm, MoveUpperImm, MoveImm, SubImm:
            begin
                decodedWord.opCode = Ins.opCode;
                decodedWord.opExt = Ins.opExt;
                decodedWord.regWrite = 1'b1;
                decodedWord.regIn = Ins.fieldLow;
                decodedWord.regB = Ins.fieldLow;
                decodedWord.immediate = immValue;
            end
            CompareImm:
            begin
                decodedWord.opCode = Ins.opCode;
                decodedWord.opExt = Ins.opExt;
                decodedWord.regA = Ins.fieldHigh;
                decodedWord.regB = Ins.fieldLow;
                decodedWord.immediate = immValue;
            end
            // Step is chosen later from the flags
            Branch, JumpCond:
            begin
                if (condValid)
                begin
                    decodedWord.aluSrc = SrcRegister;
                    if (opCode == Branch)
                        branchRequest.kind = Skip;
                    else
                        branchRequest.kind = Jump;
                    branchRequest.cond = cond;
                    branchRequest.jumpOffset = insBits[PcOffsetWidth-1:0];
                end
            end
            // Address always from register fieldHigh
            Memory:
            begin
                if (Ins.opExt == LoadExt)
                begin
                    decodedWord.opCode = RegAlu;
                    decodedWord.opExt = MoveOpExt;
                    decodedWord.regWrite = 1'b1;
                    decodedWord.regIn = Ins.fieldLow;
                    decodedWord.regB = Ins.fieldHigh;
                    decodedWord.aluSrc = SrcMemory;
                end
                else if (Ins.opExt == StoreExt)
                begin
                    decodedWord.opCode = RegAlu;
                    decodedWord.opExt = MoveOpExt;
                    decodedWord.regA = Ins.fieldLow;
                    decodedWord.regB = Ins.fieldHigh;
                    decodedWord.aluSrc = SrcRegister;
                    decodedWord.memWrite = 1'b1;
                end
            end
            JumpSpecial:
            begin
                // pcWrite also tells the sequencer to zero the step
                if (Ins.opExt == RegJumpExt)
                begin
                    decodedWord.opCode = RegAlu;
                    decodedWord.opExt = MoveOpExt;
                    decodedWord.regA = Ins.fieldHigh;
                    decodedWord.aluSrc = SrcRegister;
                    decodedWord.pcWrite = 1'b1;
                    decodedWord.pcIncrement = 1'b0;
                end
                // return address into fieldLow
                else if (Ins.opExt == StorePcExt)
                begin
                    decodedWord.opCode = RegAlu;
                    decodedWord.opExt = MoveOpExt;
                    decodedWord.regWrite = 1'b1;
                    decodedWord.regIn = Ins.fieldLow;
                    decodedWord.aluSrc = SrcProgramCounter;
                end
            end
            default:
            begin
                decodedWord.pcIncrement = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/isaPkg.sv
`default_nettype none

package isaPkg;

    //////////////////////////////////////////////////////////////////////
    // Word widths
    //////////////////////////////////////////////////////////////////////

    // Full instruction word
    localparam int InstrWidth = 16;

    // Datapath width, also the width of the extended immediate
    localparam int DataWidth = 16;

    // Step added to the program counter
    localparam int PcOffsetWidth = 8;

    // Register number in the register file
    localparam int RegIndexWidth = 4;

    //////////////////////////////////////////////////////////////////////
    // Instruction layout
    //////////////////////////////////////////////////////////////////////

    // Four nibbles, most significant first
    // The middle byte {opExt, fieldHigh} carries the immediate forms
    // The low byte {fieldHigh, fieldLow} carries the jump offset
    typedef struct packed {
        logic [3:0]               opCode;
        logic [3:0]               opExt;
        logic [RegIndexWidth-1:0] fieldHigh;
        logic [RegIndexWidth-1:0] fieldLow;
    } instrWord_t;

    // Major opcodes
    // Codes 2, 13, 14 and 15 are unused and decode as no-op
    typedef enum logic [3:0] {
        RegAlu       = 4'd0,
        Branch       = 4'd1,
        Compare      = 4'd3,
        Memory       = 4'd4,
        AddImm       = 4'd5,
        AddUnsImm    = 4'd6,
        MoveUpperImm = 4'd7,
        MoveImm      = 4'd8,
        SubImm       = 4'd9,
        JumpCond     = 4'd10,
        CompareImm   = 4'd11,
        JumpSpecial  = 4'd12
    } opCode_t;

    // Branch and conditional jump conditions, carried in opExt
    typedef enum logic [3:0] {
        GreaterEqual = 4'd0,
        Higher       = 4'd1,
        Equal        = 4'd2,
        LessThan     = 4'd3,
        LowerSame    = 4'd4
    } condition_t;

    //////////////////////////////////////////////////////////////////////
    // Processor status register
    //////////////////////////////////////////////////////////////////////

    // Flags as left by the last ALU compare
    typedef struct packed {
        logic negative;
        logic zero;
        logic greater;
        logic overflow;
        logic low;
    } psr_t;

    // ALU operation code for a plain move
    // Used by load, store, register jump and store PC
    localparam logic [3:0] MoveOpExt = 4'd13;

endpackage

`default_nettype wire

// File: src.f
+incdir+verification
rtl/isaPkg.sv
rtl/controlPkg.sv
rtl/branchResolver.sv
rtl/instructionDecoder.sv
rtl/controlSequencer.sv
rtl/cpuController.sv
verification/tbCpuController.sv

// File: verification/tbVectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// One table entry
// Instruction and flags go in, the execute-phase control word comes out
typedef struct packed {
    instrWord_t   ins;
    psr_t         psr;
    controlWord_t expected;
} vector_t;

// Hand-written entries first, random branch entries after them
localparam int NumFixed = 30;
localparam int NumRandom = 10;
localparam int NumVectors = NumFixed + NumRandom;

vector_t vectors [NumVectors];
int      vectorCount;

// Columns are instruction, flags, ALU op {opCode, opExt}, {regWrite, regIn, regA, regB},
// immediate, PC step, ALU source and {memWrite, pcWrite, pcIncrement}
task automatic addVector(input logic [15:0] ins, input logic [4:0] psr,
    input logic [7:0] aluOp, input logic [12:0] regs, input logic [15:0] imm,
    input logic [7:0] step, input aluSrc_t src, input logic [2:0] enables);
begin
    vectors[vectorCount].ins = ins;
    vectors[vectorCount].psr = psr;
    // memAddrFromPc and irWrite belong to fetch only
    vectors[vectorCount].expected = {aluOp, regs, imm, step, src,
        1'b0, enables[2], 1'b0, enables[1:0]};
    vectorCount++;
end
endtask

task automatic loadFixedVectors;
begin
    // Register ALU writes rB, register compare writes nothing
    addVector(16'h0234, 5'h00, 8'h02, 13'h1434, 16'h0000, 8'h01, SrcRegister, 3'b001);
    addVector(16'h30AB, 5'h1F, 8'h30, 13'h00AB, 16'h0000, 8'h01, SrcRegister, 3'b001);

    // One immediate form per extension
    // Add and subtract sign-extend a negative byte
    addVector(16'h5FE1, 5'h00, 8'h5F, 13'h1101, 16'hFFFE, 8'h01, SrcImmediate, 3'b001);
    addVector(16'h6F02, 5'h00, 8'h6F, 13'h1202, 16'h00F0, 8'h01, SrcImmediate, 3'b001);
    addVector(16'h7AB5, 5'h00, 8'h7A, 13'h1505, 16'hAB00, 8'h01, SrcImmediate, 3'b001);
    addVector(16'h89C6, 5'h00, 8'h89, 13'h1606, 16'h009C, 8'h01, SrcImmediate, 3'b001);
    addVector(16'h9807, 5'h00, 8'h98, 13'h1707, 16'hFF80, 8'h01, SrcImmediate, 3'b001);
    // Compare immediate fills ones above
    addVector(16'hB128, 5'h00, 8'hB1, 13'h0028, 16'hFF12, 8'h01, SrcImmediate, 3'b001);

    // Skip branches with each condition met and then missed
    addVector(16'h1000, 5'h00, 8'h00, 13'h0000, 16'h0000, 8'h02, SrcRegister, 3'b001);
    addVector(16'h1000, 5'h01, 8'h00, 13'h0000, 16'h0000, 8'h01, SrcRegister, 3'b001);
    addVector(16'h1100, 5'h00, 8'h00, 13'h0000, 16'h0000, 8'h02, SrcRegister, 3'b001);
    addVector(16'h1100, 5'h04, 8'h00, 13'h0000, 16'h0000, 8'h01, SrcRegister, 3'b001);
    addVector(16'h1200, 5'h14, 8'h00, 13'h0000, 16'h0000, 8'h02, SrcRegister, 3'b001);
    addVector(16'h1200, 5'h08, 8'h00, 13'h0000, 16'h0000, 8'h01, SrcRegister, 3'b001);
    addVector(16'h1300, 5'h08, 8'h00, 13'h0000, 16'h0000, 8'h02, SrcRegister, 3'b001);
    addVector(16'h1300, 5'h00, 8'h00, 13'h0000, 16'h0000, 8'h01, SrcRegister, 3'b001);
    addVector(16'h1400, 5'h04, 8'h00, 13'h0000, 16'h0000, 8'h02, SrcRegister, 3'b001);
    addVector(16'h1400, 5'h1B, 8'h00, 13'h0000, 16'h0000, 8'h01, SrcRegister, 3'b001);

    // Conditional jumps take the low byte when taken
    addVector(16'hA03C, 5'h00, 8'h00, 13'h0000, 16'h0000, 8'h3C, SrcRegister, 3'b001);
    addVector(16'hA2F0, 5'h08, 8'h00, 13'h0000, 16'h0000, 8'h01, SrcRegister, 3'b001);
    addVector(16'hA380, 5'h01, 8'h00, 13'h0000, 16'h0000, 8'h80, SrcRegister, 3'b001);

    // Register jump, store PC, load and store
    addVector(16'hC050, 5'h1F, 8'h0D, 13'h0050, 16'h0000, 8'h00, SrcRegister, 3'b010);
    addVector(16'hC107, 5'h00, 8'h0D, 13'h1700, 16'h0000, 8'h01, SrcProgramCounter, 3'b001);
    addVector(16'h4039, 5'h00, 8'h0D, 13'h1903, 16'h0000, 8'h01, SrcMemory, 3'b001);
    addVector(16'h4139, 5'h00, 8'h0D, 13'h0093, 16'h0000, 8'h01, SrcRegister, 3'b101);

    // Unlisted condition codes, unused opcodes and sub-operations
    addVector(16'h1700, 5'h1F, 8'h00, 13'h0000, 16'h0000, 8'h01, SrcImmediate, 3'b001);
    addVector(16'h2345, 5'h00, 8'h00, 13'h0000, 16'h0000, 8'h01, SrcImmediate, 3'b001);
    addVector(16'hFFFF, 5'h1F, 8'h00, 13'h0000, 16'h0000, 8'h01, SrcImmediate, 3'b001);
    addVector(16'h4239, 5'h00, 8'h00, 13'h0000, 16'h0000, 8'h01, SrcImmediate, 3'b001);
    addVector(16'hA512, 5'h00, 8'h00, 13'h0000, 16'h0000, 8'h01, SrcImmediate, 3'b001);
end
endtask

`endif

// File: verification/tbCpuController.sv
`timescale 1ns/1ns
`default_nettype none

module tbCpuController;

    import isaPkg::*;
    import controlPkg::*;

    localparam int ClockPeriod = 20;
    // Inputs change this long after the rising edge
    localparam int DriveDelay = 2;
    localparam int ResetCycles = 5;

    logic         Clock;
    logic         Reset;
    instrWord_t   Ins;
    psr_t         Psr;
    controlWord_t Control;

    // Expected word in every fetch cycle
    controlWord_t fetchWord;
    integer       seed = 32'hbacc_ac01;
    int           errorCount;
    int           checkCount;

    `include "tbVectors.svh"

    cpuController dut0
    (
        .Clock   (Clock),
        .Reset   (Reset),
        .Ins     (Ins),
        .Psr     (Psr),
        .Control (Control)
    );

    initial
    begin
        Clock = 1'b0;
        forever #(ClockPeriod / 2) Clock = ~Clock;
    end

    // Two cycles per entry plus a margin that covers reset
    initial
    begin
        #((NumVectors * 2 + 20) * ClockPeriod);
        $display("Watchdog expired before the table was done");
        $display("** FAIL **");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Expected values and checks
    //////////////////////////////////////////////////////////////////////

    // Branch condition rules of the instruction set
    function automatic logic conditionHolds(input logic [3:0] cond, input psr_t flags);
        begin
            case (cond)
                GreaterEqual: conditionHolds = !flags.zero && !flags.low;
                Higher:       conditionHolds = !flags.zero && !flags.greater;
                Equal:        conditionHolds = !flags.zero;
                LessThan:     conditionHolds = flags.zero || flags.low;
                LowerSame:    conditionHolds = flags.greater;
                default:      conditionHolds = 1'b0;
            endcase
        end
    endfunction

    // Skip or jump with a random condition and random flags
    task automatic addRandomVectors;
        logic [3:0] op;
        logic [3:0] cond;
        logic [7:0] lowByte;
        logic [4:0] flags;
        logic [7:0] step;
        begin
            repeat (NumRandom)
            begin
                op = ($random(seed) & 1) ? JumpCond : Branch;
                cond = 4'({$random(seed)} % 5);
                lowByte = 8'($random(seed));
                flags = 5'($random(seed));
                // Taken skip steps 2, taken jump steps by the low byte
                if (!conditionHolds(cond, flags))
                    step = 8'h01;
                else if (op == JumpCond)
                    step = lowByte;
                else
                    step = 8'h02;
                addVector({op, cond, lowByte}, flags, 8'h00, 13'h0000, 16'h0000, step,
                    SrcRegister, 3'b001);
            end
        end
    endtask

    task automatic checkField(input string name, input logic [15:0] expected,
        input logic [15:0] actual, input string where);
        begin
            if (actual !== expected)
            begin
                $display("Fail Control.%s at %s: expected %h, got %h",
                    name, where, expected, actual);
                errorCount++;
            end
        end
    endtask

    // Every field of Control against the expected word
    task automatic checkWord(input controlWord_t expected, input string phase,
        input int index);
        string where;
        begin
            where = $sformatf("%s %0d", phase, index);
            checkCount++;
            checkField("opCode", 16'(expected.opCode), 16'(Control.opCode), where);
            checkField("opExt", 16'(expected.opExt), 16'(Control.opExt), where);
            checkField("regWrite", 16'(expected.regWrite), 16'(Control.regWrite), where);
            checkField("regIn", 16'(expected.regIn), 16'(Control.regIn), where);
            checkField("regA", 16'(expected.regA), 16'(Control.regA), where);
            checkField("regB", 16'(expected.regB), 16'(Control.regB), where);
            checkField("immediate", expected.immediate, Control.immediate, where);
            checkField("pcOffset", 16'(expected.pcOffset), 16'(Control.pcOffset), where);
            checkField("aluSrc", 16'(expected.aluSrc), 16'(Control.aluSrc), where);
            checkField("memAddrFromPc", 16'(expected.memAddrFromPc),
                16'(Control.memAddrFromPc), where);
            checkField("memWrite", 16'(expected.memWrite), 16'(Control.memWrite), where);
            checkField("irWrite", 16'(expected.irWrite), 16'(Control.irWrite), where);
            checkField("pcWrite", 16'(expected.pcWrite), 16'(Control.pcWrite), where);
            checkField("pcIncrement", 16'(expected.pcIncrement),
                16'(Control.pcIncrement), where);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        Reset = 1'b0;
        Ins = '0;
        Psr = '0;
        errorCount = 0;
        checkCount = 0;
        vectorCount = 0;
        fetchWord = '0;
        fetchWord.memAddrFromPc = 1'b1;
        fetchWord.irWrite = 1'b1;
        loadFixedVectors();
        addRandomVectors();
        if (vectorCount != NumVectors)
        begin
            $display("Vector table holds %0d entries instead of %0d", vectorCount, NumVectors);
            errorCount++;
        end

        // All controls stay low while Reset is held
        for (int n = 0; n < ResetCycles; n++)
        begin
            @(posedge Clock);
            #(ClockPeriod - 1);
            checkWord('0, "reset", n);
        end
        @(posedge Clock);
        #(DriveDelay);
        Reset = 1'b1;

        // One fetch/execute pair per entry
        // Sampled 1 ns before the next rising edge
        for (int i = 0; i < vectorCount; i++)
        begin
            Ins = vectors[i].ins;
            Psr = vectors[i].psr;
            #(ClockPeriod - DriveDelay - 1);
            checkWord(fetchWord, "fetch", i);
            @(posedge Clock);
            #(ClockPeriod - 1);
            checkWord(vectors[i].expected, "execute", i);
            @(posedge Clock);
            #(DriveDelay);
        end

        $display("Words checked %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
